// ==== Makefile ====
# Verilator build and run of the bus unit testbench

LOG := sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --timescale 1ns/1ps -f gb80_bus_unit.f \
		--top-module tb_gb80_bus_unit -Mdir obj_dir
	./obj_dir/Vtb_gb80_bus_unit | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== gb80_bus_unit.f ====
hdl/gb80_mem_pkg.sv
hdl/gb80_irq_pkg.sv
hdl/bus_latch.sv
hdl/hram.sv
hdl/mem_port_router.sv
hdl/interrupt_ctrl.sv
hdl/gb80_bus_unit.sv
testbench/clock_gen.sv
testbench/tb_gb80_bus_unit.sv

// ==== hdl/bus_latch.sv ====
`timescale 1ns/1ps

module bus_latch #(
   parameter type payload_t = logic
) (
   input  logic     clock,
   input  logic     reset,
   // Load from the core side
   input  logic     core_load,
   input  payload_t core_value,
   // Load from the memory side
   input  logic     mem_load,
   input  payload_t mem_value,
   output payload_t value
);

   payload_t held;

   // Core side beats memory side
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         held <= '0;
      end else if (core_load) begin
         held <= core_value;
      end else if (mem_load) begin
         held <= mem_value;
      end
   end

   // Always visible to both sides
   assign value = held;

endmodule

// ==== hdl/gb80_bus_unit.sv ====
`timescale 1ns/1ps

module gb80_bus_unit (
   input  logic                     clock,
   input  logic                     reset,
   // Core side
   input  gb80_mem_pkg::addr_t      core_addr,
   input  logic                     addr_load,
   input  gb80_mem_pkg::data_t      core_data,
   input  logic                     data_load,
   input  logic                     addr_drive,
   input  logic                     mem_read,
   input  logic                     mem_write,
   input  logic                     mem_disable,
   // External memory
   input  gb80_mem_pkg::data_t      mem_data_in,
   output gb80_mem_pkg::addr_t      mem_addr,
   output logic                     mem_addr_oe,
   output gb80_mem_pkg::data_t      mem_data_out,
   output logic                     mem_data_oe,
   output logic                     mem_we_l,
   output logic                     mem_re_l,
   output gb80_mem_pkg::data_t      latched_data,
   // Interrupts
   input  gb80_irq_pkg::irq_flags_t irq_request,
   input  logic                     irq_ack,
   input  gb80_irq_pkg::irq_flags_t ie_in,
   input  logic                     ie_load,
   input  logic                     ime_set,
   input  logic                     ime_clear,
   output gb80_irq_pkg::irq_flags_t if_flags,
   output gb80_irq_pkg::irq_flags_t ie_flags,
   output logic                     ime,
   output logic                     irq_take,
   output gb80_mem_pkg::data_t      irq_vector
);

   gb80_mem_pkg::addr_t       addr_value;
   gb80_mem_pkg::data_t       data_value;
   gb80_mem_pkg::data_t       ext_read_data;
   gb80_mem_pkg::data_t       hram_read_data;
   gb80_mem_pkg::hram_index_t hram_index;
   logic                      hram_write;
   logic                      ie_write;

   // Address latch, memory never loads it
   bus_latch #(
      .payload_t(gb80_mem_pkg::addr_t)
   ) addr_latch (
      .clock     (clock),
      .reset     (reset),
      .core_load (addr_load),
      .core_value(core_addr),
      .mem_load  (1'b0),
      .mem_value ('0),
      .value     (addr_value)
   );

   // Data latch, filled by the core or by a read
   bus_latch #(
      .payload_t(gb80_mem_pkg::data_t)
   ) data_latch (
      .clock     (clock),
      .reset     (reset),
      .core_load (data_load),
      .core_value(core_data),
      .mem_load  (mem_read),
      .mem_value (ext_read_data),
      .value     (data_value)
   );

   mem_port_router router (
      .address    (addr_value),
      .addr_drive (addr_drive),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .mem_disable(mem_disable),
      .hram_data  (hram_read_data),
      .mem_data_in(mem_data_in),
      .hram_hit   (),
      .hram_index (hram_index),
      .hram_write (hram_write),
      .read_data  (ext_read_data),
      .mem_we_l   (mem_we_l),
      .mem_re_l   (mem_re_l),
      .mem_addr_oe(mem_addr_oe),
      .mem_data_oe(mem_data_oe),
      .ie_write   (ie_write)
   );

   // High RAM takes its byte from the data latch
   hram high_ram (
      .clock     (clock),
      .write     (hram_write),
      .index     (hram_index),
      .write_data(data_value),
      .read_data (hram_read_data)
   );

   // IE store uses the low flag bits of the data latch
   interrupt_ctrl irq_ctrl (
      .clock        (clock),
      .reset        (reset),
      .irq_request  (irq_request),
      .irq_ack      (irq_ack),
      .ie_load      (ie_load),
      .ie_in        (ie_in),
      .ie_write     (ie_write),
      .ie_write_data(data_value[gb80_irq_pkg::IRQ_COUNT-1:0]),
      .ime_set      (ime_set),
      .ime_clear    (ime_clear),
      .if_flags     (if_flags),
      .ie_flags     (ie_flags),
      .ime          (ime),
      .irq_take     (irq_take),
      .irq_vector   (irq_vector)
   );

   // Latch contents go straight to the pins
   assign mem_addr = addr_value;
   assign mem_data_out = data_value;
   assign latched_data = data_value;

endmodule

// ==== hdl/gb80_irq_pkg.sv ====
package gb80_irq_pkg;

   // Interrupt sources
   localparam int IRQ_COUNT = 5;

   // One flag bit per source
   typedef logic [IRQ_COUNT-1:0] irq_flags_t;

   // Bit positions, lowest bit has highest priority
   localparam int IRQ_VBLANK = 0;
   localparam int IRQ_LCDC = 1;
   localparam int IRQ_TIMA = 2;
   localparam int IRQ_SERIAL = 3;
   localparam int IRQ_HILO = 4;

   // Winning source number
   typedef logic [2:0] irq_sel_t;

   // Restart address of source 0
   localparam logic [7:0] IRQ_VECTOR_BASE = 8'h40;

   // Spacing of the restart vectors
   localparam logic [7:0] IRQ_VECTOR_STEP = 8'h08;

   // Interrupts globally enabled out of reset
   localparam logic IME_RESET_VALUE = 1'b1;

endpackage

// ==== hdl/gb80_mem_pkg.sv ====
package gb80_mem_pkg;

   // Core address bus
   typedef logic [15:0] addr_t;

   // Core data bus
   typedef logic [7:0] data_t;

   // High-memory window, served on chip
   localparam addr_t HRAM_START = 16'hFF80;
   localparam addr_t HRAM_END = 16'hFFFE;

   // One byte per address in the window
   localparam int HRAM_DEPTH = 127;

   // Offset into high RAM
   typedef logic [6:0] hram_index_t;

   // Interrupt-enable register, last byte of the map
   localparam addr_t MMIO_IE = 16'hFFFF;

endpackage

// ==== hdl/hram.sv ====
`timescale 1ns/1ps

module hram (
   input  logic                      clock,
   // Write strobe, high window only
   input  logic                      write,
   input  gb80_mem_pkg::hram_index_t index,
   input  gb80_mem_pkg::data_t       write_data,
   output gb80_mem_pkg::data_t       read_data
);

   // Storage for 0xFF80 through 0xFFFE
   gb80_mem_pkg::data_t mem [0:gb80_mem_pkg::HRAM_DEPTH-1];

   // Byte written at the edge
   always_ff @(posedge clock) begin
      if (write) begin
         mem[index] <= write_data;
      end
   end

   // Read path is asynchronous
   // so a byte returns in the same cycle as its address
   assign read_data = mem[index];

endmodule

// ==== hdl/interrupt_ctrl.sv ====
`timescale 1ns/1ps

module interrupt_ctrl (
   input  logic                     clock,
   input  logic                     reset,
   // Request bits from peripherals
   input  gb80_irq_pkg::irq_flags_t irq_request,
   // Core takes the winner
   input  logic                     irq_ack,
   // Direct IE load
   input  logic                     ie_load,
   input  gb80_irq_pkg::irq_flags_t ie_in,
   // IE load through a store to 0xFFFF
   input  logic                     ie_write,
   input  gb80_irq_pkg::irq_flags_t ie_write_data,
   // Master enable control
   input  logic                     ime_set,
   input  logic                     ime_clear,
   output gb80_irq_pkg::irq_flags_t if_flags,
   output gb80_irq_pkg::irq_flags_t ie_flags,
   output logic                     ime,
   output logic                     irq_take,
   output gb80_mem_pkg::data_t      irq_vector
);

   gb80_irq_pkg::irq_flags_t pending;
   gb80_irq_pkg::irq_flags_t ack_mask;
   gb80_irq_pkg::irq_sel_t   irq_sel;
   logic                     any_pending;

   // Only enabled flags compete
   assign pending = if_flags & ie_flags;
   assign any_pending = |pending;

   // Priority encoder, lowest set bit wins
   always_comb begin
      irq_sel = gb80_irq_pkg::irq_sel_t'(gb80_irq_pkg::IRQ_VBLANK);
      ack_mask = '0;
      // Walk down so the lowest bit is assigned last
      for (int i = gb80_irq_pkg::IRQ_HILO; i >= gb80_irq_pkg::IRQ_VBLANK; i--) begin
         if (pending[i]) begin
            irq_sel = gb80_irq_pkg::irq_sel_t'(i);
            ack_mask = gb80_irq_pkg::irq_flags_t'(1) << i;
         end
      end
   end

   // Restart vector, 0x40 when idle
   assign irq_vector = gb80_irq_pkg::IRQ_VECTOR_BASE +
                       gb80_irq_pkg::IRQ_VECTOR_STEP * gb80_mem_pkg::data_t'(irq_sel);

   assign irq_take = ime & any_pending;

   // IF register
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_flags <= '0;
      end else if (irq_ack) begin
         // New request beats the acknowledge on the same bit
         if_flags <= (if_flags & ~ack_mask) | irq_request;
      end else begin
         if_flags <= if_flags | irq_request;
      end
   end

   // IE register, direct load first
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_flags <= '0;
      end else if (ie_load) begin
         ie_flags <= ie_in;
      end else if (ie_write) begin
         ie_flags <= ie_write_data;
      end
   end

   // IME, set wins over clear
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ime <= gb80_irq_pkg::IME_RESET_VALUE;
      end else if (ime_set) begin
         ime <= 1'b1;
      end else if (ime_clear) begin
         ime <= 1'b0;
      end
   end

endmodule

// ==== hdl/mem_port_router.sv ====
`timescale 1ns/1ps

module mem_port_router (
   // Latched address
   input  gb80_mem_pkg::addr_t       address,
   // Core strobes
   input  logic                      addr_drive,
   input  logic                      mem_read,
   input  logic                      mem_write,
   input  logic                      mem_disable,
   // Read sources
   input  gb80_mem_pkg::data_t       hram_data,
   input  gb80_mem_pkg::data_t       mem_data_in,
   // High RAM side
   output logic                      hram_hit,
   output gb80_mem_pkg::hram_index_t hram_index,
   output logic                      hram_write,
   // Byte for the data latch
   output gb80_mem_pkg::data_t       read_data,
   // External pins, strobes active low
   output logic                      mem_we_l,
   output logic                      mem_re_l,
   output logic                      mem_addr_oe,
   output logic                      mem_data_oe,
   // Store to the IE register
   output logic                      ie_write
);

   gb80_mem_pkg::addr_t offset;
   logic                ie_hit;
   logic                ext_ok;

   // Window decode
   assign hram_hit = (address >= gb80_mem_pkg::HRAM_START) &&
                     (address <= gb80_mem_pkg::HRAM_END);
   assign ie_hit = (address == gb80_mem_pkg::MMIO_IE);

   // Offset from window base, low bits only
   assign offset = address - gb80_mem_pkg::HRAM_START;
   assign hram_index = offset[6:0];
   assign hram_write = mem_write & hram_hit;

   // Pins see only off-chip addresses, and nothing under disable
   assign ext_ok = ~hram_hit & ~ie_hit & ~mem_disable;

   assign mem_we_l = ~(mem_write & ext_ok);
   assign mem_re_l = ~(mem_read & ext_ok);

   // Address pins drive for any phase of an external access
   assign mem_addr_oe = ext_ok & (addr_drive | mem_read | mem_write);
   // Data pins drive only on a store
   assign mem_data_oe = ext_ok & mem_write;

   // Read byte select
   always_comb begin
      if (hram_hit) begin
         read_data = hram_data;
      end else if (ie_hit || mem_disable) begin
         // IE not readable here, disabled bus floats to zero
         read_data = '0;
      end else begin
         read_data = mem_data_in;
      end
   end

   // IE store, independent of memory-disable
   assign ie_write = mem_write & ie_hit;

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
   output logic clock,
   output logic reset
);

   // 40 ns period
   localparam int HALF_PERIOD = 20;
   localparam int RESET_CYCLES = 16;

   initial begin
      clock = 1'b0;
      forever #(HALF_PERIOD) clock = ~clock;
   end

   // Released on a falling edge, well away from the rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(negedge clock);
      reset = 1'b0;
   end

endmodule

// ==== testbench/tb_gb80_bus_unit.sv ====
`timescale 1ns/1ps

module tb_gb80_bus_unit;

   localparam int CLOCK_PERIOD = 40;
   localparam int SETTLE = 1;
   localparam int HRAM_WRITES = 16;
   localparam int IRQ_ROUNDS = 6;
   // Cycles per test, summed: reset, external, high RAM, disable, priority, IE store
   localparam int TEST_CYCLES = 16 + 17 + 4 * HRAM_WRITES + 8 + 6 * IRQ_ROUNDS + 12 + 8;

   logic                     clock;
   logic                     reset;
   gb80_mem_pkg::addr_t      core_addr;
   logic                     addr_load;
   gb80_mem_pkg::data_t      core_data;
   logic                     data_load;
   logic                     addr_drive;
   logic                     mem_read;
   logic                     mem_write;
   logic                     mem_disable;
   gb80_mem_pkg::data_t      mem_data_in;
   gb80_mem_pkg::addr_t      mem_addr;
   logic                     mem_addr_oe;
   gb80_mem_pkg::data_t      mem_data_out;
   logic                     mem_data_oe;
   logic                     mem_we_l;
   logic                     mem_re_l;
   gb80_mem_pkg::data_t      latched_data;
   gb80_irq_pkg::irq_flags_t irq_request;
   logic                     irq_ack;
   gb80_irq_pkg::irq_flags_t ie_in;
   logic                     ie_load;
   logic                     ime_set;
   logic                     ime_clear;
   gb80_irq_pkg::irq_flags_t if_flags;
   gb80_irq_pkg::irq_flags_t ie_flags;
   logic                     ime;
   logic                     irq_take;
   gb80_mem_pkg::data_t      irq_vector;

   int          errors;
   int          tests_run;
   logic [31:0] lfsr_state;

   clock_gen clocks (
      .clock(clock),
      .reset(reset)
   );

   gb80_bus_unit dut0 (
      .clock       (clock),
      .reset       (reset),
      .core_addr   (core_addr),
      .addr_load   (addr_load),
      .core_data   (core_data),
      .data_load   (data_load),
      .addr_drive  (addr_drive),
      .mem_read    (mem_read),
      .mem_write   (mem_write),
      .mem_disable (mem_disable),
      .mem_data_in (mem_data_in),
      .mem_addr    (mem_addr),
      .mem_addr_oe (mem_addr_oe),
      .mem_data_out(mem_data_out),
      .mem_data_oe (mem_data_oe),
      .mem_we_l    (mem_we_l),
      .mem_re_l    (mem_re_l),
      .latched_data(latched_data),
      .irq_request (irq_request),
      .irq_ack     (irq_ack),
      .ie_in       (ie_in),
      .ie_load     (ie_load),
      .ime_set     (ime_set),
      .ime_clear   (ime_clear),
      .if_flags    (if_flags),
      .ie_flags    (ie_flags),
      .ime         (ime),
      .irq_take    (irq_take),
      .irq_vector  (irq_vector)
   );

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] random_bits(int count);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   // Highest priority is the lowest set bit
   function automatic int lowest_source(logic [4:0] flags);
      int source;
      logic found;
      source = 0;
      found = 1'b0;
      for (int i = 0; i < 5; i++) begin
         if (flags[i] && !found) begin
            source = i;
            found = 1'b1;
         end
      end
      return source;
   endfunction

   task automatic report_mismatch(string what, logic [15:0] got, logic [15:0] expected);
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
   endtask

   // From one falling edge to the next
   task automatic next_cycle();
      @(posedge clock);
      @(negedge clock);
   endtask

   // Load both latches, then one store cycle
   task automatic write_byte(logic [15:0] addr, logic [7:0] data, logic ext);
      core_addr = addr;
      core_data = data;
      addr_load = 1'b1;
      data_load = 1'b1;
      next_cycle();
      addr_load = 1'b0;
      data_load = 1'b0;
      mem_write = 1'b1;
      addr_drive = 1'b1;
      #SETTLE;
      if (mem_addr !== addr) report_mismatch("mem_addr", mem_addr, addr);
      if (mem_data_out !== data) report_mismatch("mem_data_out", 16'(mem_data_out), 16'(data));
      if (mem_we_l !== !ext) report_mismatch("mem_we_l on write", 16'(mem_we_l), 16'(!ext));
      if (mem_re_l !== 1'b1) report_mismatch("mem_re_l on write", 16'(mem_re_l), 16'h1);
      if (mem_addr_oe !== ext) report_mismatch("mem_addr_oe on write", 16'(mem_addr_oe), 16'(ext));
      if (mem_data_oe !== ext) report_mismatch("mem_data_oe on write", 16'(mem_data_oe), 16'(ext));
      next_cycle();
      mem_write = 1'b0;
      addr_drive = 1'b0;
   endtask

   // Load the address, then one read cycle with ext_value on the pins
   task automatic read_byte(logic [15:0] addr, logic [7:0] ext_value, logic ext,
                            logic [7:0] expected);
      core_addr = addr;
      addr_load = 1'b1;
      next_cycle();
      addr_load = 1'b0;
      mem_read = 1'b1;
      mem_data_in = ext_value;
      #SETTLE;
      if (mem_addr !== addr) report_mismatch("mem_addr", mem_addr, addr);
      if (mem_re_l !== !ext) report_mismatch("mem_re_l on read", 16'(mem_re_l), 16'(!ext));
      if (mem_we_l !== 1'b1) report_mismatch("mem_we_l on read", 16'(mem_we_l), 16'h1);
      if (mem_addr_oe !== ext) report_mismatch("mem_addr_oe on read", 16'(mem_addr_oe), 16'(ext));
      if (mem_data_oe !== 1'b0) report_mismatch("mem_data_oe on read", 16'(mem_data_oe), 16'h0);
      next_cycle();
      mem_read = 1'b0;
      // Latch was loaded at the rising edge
      if (latched_data !== expected) begin
         report_mismatch("latched_data", 16'(latched_data), 16'(expected));
      end
   endtask

   task automatic check_reset_state();
      tests_run++;
      if (mem_we_l !== 1'b1) report_mismatch("mem_we_l after reset", 16'(mem_we_l), 16'h1);
      if (mem_re_l !== 1'b1) report_mismatch("mem_re_l after reset", 16'(mem_re_l), 16'h1);
      if (mem_addr_oe !== 1'b0) report_mismatch("mem_addr_oe after reset", 16'(mem_addr_oe), 16'h0);
      if (mem_data_oe !== 1'b0) report_mismatch("mem_data_oe after reset", 16'(mem_data_oe), 16'h0);
      if (if_flags !== 5'h00) report_mismatch("if_flags after reset", 16'(if_flags), 16'h0);
      if (ie_flags !== 5'h00) report_mismatch("ie_flags after reset", 16'(ie_flags), 16'h0);
      if (ime !== 1'b1) report_mismatch("ime after reset", 16'(ime), 16'h1);
      if (irq_take !== 1'b0) report_mismatch("irq_take after reset", 16'(irq_take), 16'h0);
   endtask

   task automatic external_access();
      logic [31:0] bits;
      logic [15:0] addr;
      tests_run++;
      for (int n = 0; n < 4; n++) begin
         bits = random_bits(16);
         addr = bits[15:0];
         // Keep below the high window
         if (addr >= 16'hFF80) addr = addr - 16'h0100;
         bits = random_bits(8);
         write_byte(addr, bits[7:0], 1'b1);
         bits = random_bits(8);
         read_byte(addr, bits[7:0], 1'b1, bits[7:0]);
      end
      // Address phase alone enables only the address pins
      addr_drive = 1'b1;
      #SETTLE;
      if (mem_addr_oe !== 1'b1) begin
         report_mismatch("mem_addr_oe on address phase", 16'(mem_addr_oe), 16'h1);
      end
      if (mem_data_oe !== 1'b0) begin
         report_mismatch("mem_data_oe on address phase", 16'(mem_data_oe), 16'h0);
      end
      if (mem_we_l !== 1'b1) report_mismatch("mem_we_l on address phase", 16'(mem_we_l), 16'h1);
      if (mem_re_l !== 1'b1) report_mismatch("mem_re_l on address phase", 16'(mem_re_l), 16'h1);
      next_cycle();
      addr_drive = 1'b0;
   endtask

   task automatic high_ram_readback();
      logic [31:0] bits;
      logic [6:0]  offset;
      logic [15:0] addr;
      logic [7:0]  model [0:126];
      logic [15:0] written [$];
      tests_run++;
      for (int n = 0; n < HRAM_WRITES; n++) begin
         bits = random_bits(7);
         offset = bits[6:0];
         // 0xFFFF is the IE register, not RAM
         if (offset == 7'h7F) offset = 7'h00;
         addr = 16'hFF80 + 16'(offset);
         bits = random_bits(8);
         write_byte(addr, bits[7:0], 1'b0);
         model[offset] = bits[7:0];
         written.push_back(addr);
      end
      foreach (written[i]) begin
         // Pin data must be ignored inside the window
         bits = random_bits(8);
         read_byte(written[i], bits[7:0], 1'b0, model[written[i][6:0]]);
      end
   endtask

   task automatic disabled_memory();
      logic [31:0] bits;
      logic [15:0] addr;
      logic [7:0]  data;
      tests_run++;
      mem_disable = 1'b1;
      bits = random_bits(15);
      addr = bits[15:0];
      bits = random_bits(8);
      write_byte(addr, bits[7:0], 1'b0);
      bits = random_bits(8);
      read_byte(addr, bits[7:0] | 8'h01, 1'b0, 8'h00);
      // High RAM unaffected
      bits = random_bits(6);
      addr = 16'hFF80 + 16'(bits[5:0]);
      bits = random_bits(8);
      data = bits[7:0];
      write_byte(addr, data, 1'b0);
      read_byte(addr, ~data, 1'b0, data);
      mem_disable = 1'b0;
   endtask

   task automatic interrupt_priority();
      logic [31:0] bits;
      logic [4:0]  flags;
      logic [7:0]  vector;
      int          source;
      tests_run++;
      ie_in = 5'h1F;
      ie_load = 1'b1;
      next_cycle();
      ie_load = 1'b0;
      if (ie_flags !== 5'h1F) report_mismatch("ie_flags after load", 16'(ie_flags), 16'h1F);
      for (int round = 0; round < IRQ_ROUNDS; round++) begin
         bits = random_bits(5);
         flags = bits[4:0];
         if (flags == 5'h00) flags = 5'h10;
         irq_request = flags;
         next_cycle();
         irq_request = 5'h00;
         if (if_flags !== flags) begin
            report_mismatch("if_flags after request", 16'(if_flags), 16'(flags));
         end
         while (flags != 5'h00) begin
            source = lowest_source(flags);
            vector = 8'h40 + 8'(8 * source);
            if (irq_take !== 1'b1) report_mismatch("irq_take pending", 16'(irq_take), 16'h1);
            if (irq_vector !== vector) begin
               report_mismatch("irq_vector", 16'(irq_vector), 16'(vector));
            end
            irq_ack = 1'b1;
            next_cycle();
            irq_ack = 1'b0;
            flags[source] = 1'b0;
            if (if_flags !== flags) begin
               report_mismatch("if_flags after ack", 16'(if_flags), 16'(flags));
            end
         end
         if (irq_take !== 1'b0) report_mismatch("irq_take idle", 16'(irq_take), 16'h0);
         if (irq_vector !== 8'h40) report_mismatch("irq_vector idle", 16'(irq_vector), 16'h40);
      end
      // Request on the acknowledged bit keeps it set
      irq_request = 5'h01;
      next_cycle();
      irq_ack = 1'b1;
      next_cycle();
      irq_request = 5'h00;
      irq_ack = 1'b0;
      if (if_flags !== 5'h01) report_mismatch("if_flags request vs ack", 16'(if_flags), 16'h01);
      irq_ack = 1'b1;
      next_cycle();
      irq_ack = 1'b0;
      // Master enable off masks the take
      ime_clear = 1'b1;
      irq_request = 5'h04;
      next_cycle();
      ime_clear = 1'b0;
      irq_request = 5'h00;
      if (ime !== 1'b0) report_mismatch("ime after clear", 16'(ime), 16'h0);
      if (if_flags !== 5'h04) report_mismatch("if_flags masked", 16'(if_flags), 16'h04);
      if (irq_take !== 1'b0) report_mismatch("irq_take with ime low", 16'(irq_take), 16'h0);
      // Set beats clear
      ime_set = 1'b1;
      ime_clear = 1'b1;
      next_cycle();
      ime_set = 1'b0;
      ime_clear = 1'b0;
      if (ime !== 1'b1) report_mismatch("ime after set and clear", 16'(ime), 16'h1);
      if (irq_take !== 1'b1) report_mismatch("irq_take with ime high", 16'(irq_take), 16'h1);
      if (irq_vector !== 8'h50) report_mismatch("irq_vector source 2", 16'(irq_vector), 16'h50);
      irq_ack = 1'b1;
      next_cycle();
      irq_ack = 1'b0;
      if (if_flags !== 5'h00) report_mismatch("if_flags cleared", 16'(if_flags), 16'h0);
   endtask

   task automatic ie_register_store();
      logic [31:0] bits;
      logic [7:0]  data;
      logic [4:0]  raised;
      logic        expected_take;
      tests_run++;
      ie_in = 5'h00;
      ie_load = 1'b1;
      next_cycle();
      ie_load = 1'b0;
      bits = random_bits(8);
      data = bits[7:0];
      // Store to 0xFFFF stays off the pins
      write_byte(16'hFFFF, data, 1'b0);
      if (ie_flags !== data[4:0]) begin
         report_mismatch("ie_flags after store", 16'(ie_flags), 16'(data[4:0]));
      end
      raised = 5'h00;
      for (int i = 0; i < 5; i++) begin
         irq_request = 5'b00001 << i;
         next_cycle();
         irq_request = 5'h00;
         raised[i] = 1'b1;
         expected_take = |(raised & data[4:0]);
         if (irq_take !== expected_take) begin
            report_mismatch("irq_take after request", 16'(irq_take), 16'(expected_take));
         end
      end
   endtask

   // Watchdog, twice the summed test length
   initial begin
      #(2 * TEST_CYCLES * CLOCK_PERIOD);
      $display("Timeout: the tests did not finish in the expected time");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      errors = 0;
      tests_run = 0;
      lfsr_state = 32'h4c4207d1;
      core_addr = '0;
      addr_load = 1'b0;
      core_data = '0;
      data_load = 1'b0;
      addr_drive = 1'b0;
      mem_read = 1'b0;
      mem_write = 1'b0;
      mem_disable = 1'b0;
      mem_data_in = '0;
      irq_request = '0;
      irq_ack = 1'b0;
      ie_in = '0;
      ie_load = 1'b0;
      ime_set = 1'b0;
      ime_clear = 1'b0;
      // Reset drops on a falling edge
      @(negedge reset);
      check_reset_state();
      external_access();
      high_ram_readback();
      disabled_memory();
      interrupt_priority();
      ie_register_store();
      $display("Tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
